// File: csr_asserts.sv
`timescale 1ns/1ps

module csr_asserts import csr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       stall_i,
  input  logic       excp_i,
  input  csr_data_t  r_data_i,
  input  csr_data_t  era_i,
  input  csr_data_t  eentry_i,
  input  logic [1:0] plv_i,
  input  logic       ie_i
);

  int fail_cnt;

  // exception wins over a return in the same commit
  a_excp_wins: assert property (@(posedge clk) disable iff (!rst_n)
    excp_i |=> ((plv_i == '0) && !ie_i))
    else begin
      fail_cnt++;
      $error("plv or ie not cleared by an exception");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |=> ($stable(r_data_i) && $stable(era_i) && $stable(eentry_i) &&
                 $stable(plv_i) && $stable(ie_i)))
    else begin
      fail_cnt++;
      $error("register or read data changed while stalled");
    end

  a_rst_rdata: assert property (@(posedge clk) !rst_n |=> (r_data_i == '0))
    else begin
      fail_cnt++;
      $error("read data not zero after reset");
    end

endmodule

bind csr_top csr_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .stall_i  (stall_i),
  .excp_i   (excp),
  .r_data_i (csr_r_data_o),
  .era_i    (era_o),
  .eentry_i (eentry_o),
  .plv_i    (crmd_plv_o),
  .ie_i     (crmd_ie_o)
);

// File: csr_counter.sv
`timescale 1ns/1ps

module csr_counter import csr_pkg::*; #(
  parameter csr_data_t CORE_ID = 32'h0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_i,
  input  csr_sel_t  wr_sel_i,
  input  csr_data_t wr_data_i,
  output csr_data_t tid_o,
  output csr_data_t count_lo_o,
  output csr_data_t count_hi_o
);

  logic [63:0] count_q;
  csr_data_t   tid_q;

  // stable counter, free running
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tid_q <= CORE_ID;
    end else if (wr_i && (wr_sel_i == SEL_TID)) begin
      tid_q <= wr_data_i;
    end
  end

  assign tid_o      = tid_q;
  assign count_lo_o = count_q[31:0];
  assign count_hi_o = count_q[63:32];

endmodule

// File: csr_ctrl.sv
`timescale 1ns/1ps

module csr_ctrl import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_i,
  input  logic      commit_i,
  input  logic      stall_i,
  input  logic      we_i,
  input  logic      excp_i,
  input  logic      ertn_i,
  input  csr_addr_t w_addr_i,
  input  csr_data_t w_mask_i,
  input  csr_data_t w_data_i,
  input  csr_data_t old_data_i,
  output logic      wr_o,
  output logic      excp_o,
  output logic      ertn_o,
  output csr_sel_t  wr_sel_o,
  output csr_data_t wr_data_o,
  output csr_sel_t  lookup_sel_o
);

  logic     live_q;
  logic     commit;
  csr_sel_t w_sel;

  // commits are accepted from the first cycle after reset release
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  assign commit = live_q && valid_i && commit_i && !stall_i;

  assign w_sel        = addr_to_sel(w_addr_i);
  assign wr_sel_o     = w_sel;
  assign lookup_sel_o = w_sel;

  assign wr_o   = commit && we_i;
  assign excp_o = commit && excp_i;
  // exception wins over a return in the same commit
  assign ertn_o = commit && ertn_i && !excp_i;

  // masked bits take new data, others keep the current value
  assign wr_data_o = (old_data_i & ~w_mask_i) | (w_data_i & w_mask_i);

endmodule

// File: csr_excp_regs.sv
`timescale 1ns/1ps

module csr_excp_regs import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_i,
  input  logic      excp_i,
  input  logic      ertn_i,
  input  csr_sel_t  wr_sel_i,
  input  csr_data_t wr_data_i,
  input  ecode_t    ecode_i,
  input  esubcode_t esubcode_i,
  input  csr_data_t pc_i,
  input  hw_int_t   hw_int_i,
  input  logic      timer_int_i,
  output csr_data_t crmd_o,
  output csr_data_t prmd_o,
  output csr_data_t estat_o,
  output csr_data_t era_o,
  output csr_data_t eentry_o
);

  logic [CRMD_PLV_W-1:0]    plv_q;
  logic                     ie_q;
  logic                     da_q;
  logic                     pg_q;
  logic [CRMD_DATF_W-1:0]   datf_q;
  logic [CRMD_DATM_W-1:0]   datm_q;
  logic [CRMD_PLV_W-1:0]    pplv_q;
  logic                     pie_q;
  logic [ESTAT_IS_SW_W-1:0] is_sw_q;
  hw_int_t                  is_hw_q;
  ecode_t                   ecode_q;
  esubcode_t                esubcode_q;
  csr_data_t                era_q;
  logic [31:EENTRY_VA_LSB]  eentry_va_q;

  logic crmd_we;
  logic prmd_we;
  logic estat_we;
  logic era_we;
  logic eentry_we;

  assign crmd_we   = wr_i && (wr_sel_i == SEL_CRMD);
  assign prmd_we   = wr_i && (wr_sel_i == SEL_PRMD);
  assign estat_we  = wr_i && (wr_sel_i == SEL_ESTAT);
  assign era_we    = wr_i && (wr_sel_i == SEL_ERA);
  assign eentry_we = wr_i && (wr_sel_i == SEL_EENTRY);

  // crmd, direct address mode out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      plv_q  <= '0;
      ie_q   <= 1'b0;
      da_q   <= 1'b1;
      pg_q   <= 1'b0;
      datf_q <= '0;
      datm_q <= '0;
    end else if (excp_i) begin
      plv_q <= '0;
      ie_q  <= 1'b0;
    end else if (ertn_i) begin
      plv_q <= pplv_q;
      ie_q  <= pie_q;
    end else if (crmd_we) begin
      plv_q  <= wr_data_i[CRMD_PLV_LSB +: CRMD_PLV_W];
      ie_q   <= wr_data_i[CRMD_IE];
      da_q   <= wr_data_i[CRMD_DA];
      pg_q   <= wr_data_i[CRMD_PG];
      datf_q <= wr_data_i[CRMD_DATF_LSB +: CRMD_DATF_W];
      datm_q <= wr_data_i[CRMD_DATM_LSB +: CRMD_DATM_W];
    end
  end

  // prmd, estat, era, eentry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pplv_q      <= '0;
      pie_q       <= 1'b0;
      is_sw_q     <= '0;
      is_hw_q     <= '0;
      ecode_q     <= '0;
      esubcode_q  <= '0;
      era_q       <= '0;
      eentry_va_q <= '0;
    end else begin
      is_hw_q <= hw_int_i;
      if (excp_i) begin
        pplv_q     <= plv_q;
        pie_q      <= ie_q;
        ecode_q    <= ecode_i;
        esubcode_q <= esubcode_i;
        era_q      <= pc_i;
      end else begin
        if (prmd_we) begin
          pplv_q <= wr_data_i[PRMD_PPLV_LSB +: CRMD_PLV_W];
          pie_q  <= wr_data_i[PRMD_PIE];
        end
        if (estat_we) begin
          is_sw_q <= wr_data_i[ESTAT_IS_SW_LSB +: ESTAT_IS_SW_W];
        end
        if (era_we) begin
          era_q <= wr_data_i;
        end
      end
      if (eentry_we) begin
        eentry_va_q <= wr_data_i[31:EENTRY_VA_LSB];
      end
    end
  end

  // unused fields read as zero
  always_comb begin
    crmd_o = '0;
    crmd_o[CRMD_PLV_LSB +: CRMD_PLV_W]   = plv_q;
    crmd_o[CRMD_IE]                      = ie_q;
    crmd_o[CRMD_DA]                      = da_q;
    crmd_o[CRMD_PG]                      = pg_q;
    crmd_o[CRMD_DATF_LSB +: CRMD_DATF_W] = datf_q;
    crmd_o[CRMD_DATM_LSB +: CRMD_DATM_W] = datm_q;

    prmd_o = '0;
    prmd_o[PRMD_PPLV_LSB +: CRMD_PLV_W] = pplv_q;
    prmd_o[PRMD_PIE]                    = pie_q;

    estat_o = '0;
    estat_o[ESTAT_IS_SW_LSB +: ESTAT_IS_SW_W]     = is_sw_q;
    estat_o[ESTAT_IS_HW_LSB +: $bits(hw_int_t)]   = is_hw_q;
    estat_o[ESTAT_TI]                             = timer_int_i;
    estat_o[ESTAT_ECODE_LSB +: $bits(ecode_t)]    = ecode_q;
    estat_o[ESTAT_ESUB_LSB +: $bits(esubcode_t)]  = esubcode_q;

    eentry_o = '0;
    eentry_o[31:EENTRY_VA_LSB] = eentry_va_q;
  end

  assign era_o = era_q;

endmodule

// File: csr_pkg.sv
package csr_pkg;

  typedef logic [13:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [1:0]  rdcnt_t;
  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;
  typedef logic [7:0]  hw_int_t;
  typedef logic [3:0]  csr_sel_t;

  // counter read codes
  localparam rdcnt_t RDCNT_NONE  = 2'd0;
  localparam rdcnt_t RDCNT_ID    = 2'd1;
  localparam rdcnt_t RDCNT_VLOW  = 2'd2;
  localparam rdcnt_t RDCNT_VHIGH = 2'd3;

  // register groups
  localparam csr_sel_t SEL_NONE   = 4'd0;
  localparam csr_sel_t SEL_CRMD   = 4'd1;
  localparam csr_sel_t SEL_PRMD   = 4'd2;
  localparam csr_sel_t SEL_ESTAT  = 4'd3;
  localparam csr_sel_t SEL_ERA    = 4'd4;
  localparam csr_sel_t SEL_EENTRY = 4'd5;
  localparam csr_sel_t SEL_TID    = 4'd6;
  localparam csr_sel_t SEL_TCFG   = 4'd7;
  localparam csr_sel_t SEL_TVAL   = 4'd8;
  localparam csr_sel_t SEL_TICLR  = 4'd9;

  localparam csr_addr_t CSR_CRMD   = 14'h0;
  localparam csr_addr_t CSR_PRMD   = 14'h1;
  localparam csr_addr_t CSR_ESTAT  = 14'h5;
  localparam csr_addr_t CSR_ERA    = 14'h6;
  localparam csr_addr_t CSR_EENTRY = 14'hc;
  localparam csr_addr_t CSR_TID    = 14'h40;
  localparam csr_addr_t CSR_TCFG   = 14'h41;
  localparam csr_addr_t CSR_TVAL   = 14'h42;
  localparam csr_addr_t CSR_TICLR  = 14'h44;

  // field positions
  localparam int CRMD_PLV_LSB     = 0;
  localparam int CRMD_PLV_W       = 2;
  localparam int CRMD_IE          = 2;
  localparam int CRMD_DA          = 3;
  localparam int CRMD_PG          = 4;
  localparam int CRMD_DATF_LSB    = 5;
  localparam int CRMD_DATF_W      = 2;
  localparam int CRMD_DATM_LSB    = 7;
  localparam int CRMD_DATM_W      = 2;
  localparam int PRMD_PPLV_LSB    = 0;
  localparam int PRMD_PIE         = 2;
  localparam int ESTAT_IS_SW_LSB  = 0;
  localparam int ESTAT_IS_SW_W    = 2;
  localparam int ESTAT_IS_HW_LSB  = 2;
  localparam int ESTAT_TI         = 11;
  localparam int ESTAT_ECODE_LSB  = 16;
  localparam int ESTAT_ESUB_LSB   = 22;
  localparam int EENTRY_VA_LSB    = 6;
  localparam int TCFG_EN          = 0;
  localparam int TCFG_PERIODIC    = 1;
  localparam int TCFG_INITVAL_LSB = 2;
  localparam int TICLR_CLR        = 0;

  // shared by the write decode and the read port
  function automatic csr_sel_t addr_to_sel(csr_addr_t addr);
    case (addr)
      CSR_CRMD:   return SEL_CRMD;
      CSR_PRMD:   return SEL_PRMD;
      CSR_ESTAT:  return SEL_ESTAT;
      CSR_ERA:    return SEL_ERA;
      CSR_EENTRY: return SEL_EENTRY;
      CSR_TID:    return SEL_TID;
      CSR_TCFG:   return SEL_TCFG;
      CSR_TVAL:   return SEL_TVAL;
      CSR_TICLR:  return SEL_TICLR;
      default:    return SEL_NONE;
    endcase
  endfunction

endpackage

// File: csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall_i,
  input  csr_addr_t r_addr_i,
  input  rdcnt_t    rdcnt_i,
  input  csr_sel_t  lookup_sel_i,
  input  csr_data_t crmd_i,
  input  csr_data_t prmd_i,
  input  csr_data_t estat_i,
  input  csr_data_t era_i,
  input  csr_data_t eentry_i,
  input  csr_data_t tid_i,
  input  csr_data_t tcfg_i,
  input  csr_data_t tval_i,
  input  csr_data_t count_lo_i,
  input  csr_data_t count_hi_i,
  output csr_data_t r_data_o,
  output csr_data_t old_data_o
);

  csr_data_t sel_val [0:15];
  csr_sel_t  rd_sel;
  csr_data_t rd_next;

  // group values, ticlr and unknown groups stay zero
  always_comb begin
    sel_val = '{default: '0};
    sel_val[SEL_CRMD]   = crmd_i;
    sel_val[SEL_PRMD]   = prmd_i;
    sel_val[SEL_ESTAT]  = estat_i;
    sel_val[SEL_ERA]    = era_i;
    sel_val[SEL_EENTRY] = eentry_i;
    sel_val[SEL_TID]    = tid_i;
    sel_val[SEL_TCFG]   = tcfg_i;
    sel_val[SEL_TVAL]   = tval_i;
  end

  // current value of the write target, for the merge
  assign old_data_o = sel_val[lookup_sel_i];

  assign rd_sel = addr_to_sel(r_addr_i);

  // counter reads override the address
  always_comb begin
    case (rdcnt_i)
      RDCNT_NONE:  rd_next = sel_val[rd_sel];
      RDCNT_ID:    rd_next = tid_i;
      RDCNT_VLOW:  rd_next = count_lo_i;
      RDCNT_VHIGH: rd_next = count_hi_i;
      default:     rd_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_data_o <= '0;
    end else if (!stall_i) begin
      r_data_o <= rd_next;
    end
  end

endmodule

// File: csr_timer.sv
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_i,
  input  csr_sel_t  wr_sel_i,
  input  csr_data_t wr_data_i,
  output csr_data_t tcfg_o,
  output csr_data_t tval_o,
  output logic      timer_int_o
);

  logic                       tcfg_en_q;
  logic                       tcfg_periodic_q;
  logic [31:TCFG_INITVAL_LSB] initval_q;
  csr_data_t                  tval_q;
  csr_data_t                  reload_val;
  logic                       timer_en_q;
  logic                       timer_int_q;

  logic tcfg_we;
  logic ticlr_clr;
  logic counting;
  logic expire;

  assign tcfg_we    = wr_i && (wr_sel_i == SEL_TCFG);
  assign ticlr_clr  = wr_i && (wr_sel_i == SEL_TICLR) && wr_data_i[TICLR_CLR];
  assign counting   = timer_en_q && !tcfg_we;
  assign expire     = counting && (tval_q == '0);
  assign reload_val = {initval_q, {TCFG_INITVAL_LSB{1'b0}}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_en_q       <= 1'b0;
      tcfg_periodic_q <= 1'b0;
      initval_q       <= '0;
    end else if (tcfg_we) begin
      tcfg_en_q       <= wr_data_i[TCFG_EN];
      tcfg_periodic_q <= wr_data_i[TCFG_PERIODIC];
      initval_q       <= wr_data_i[31:TCFG_INITVAL_LSB];
    end
  end

  // one-shot timer drops its enable on expiry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer_en_q <= 1'b0;
    end else if (tcfg_we) begin
      timer_en_q <= wr_data_i[TCFG_EN];
    end else if (expire) begin
      timer_en_q <= tcfg_periodic_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tval_q <= '0;
    end else if (tcfg_we && wr_data_i[TCFG_EN]) begin
      tval_q <= {wr_data_i[31:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
    end else if (expire) begin
      tval_q <= tcfg_periodic_q ? reload_val : '1;
    end else if (counting) begin
      tval_q <= tval_q - 32'd1;
    end
  end

  // ticlr clear beats a new expiry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer_int_q <= 1'b0;
    end else if (ticlr_clr) begin
      timer_int_q <= 1'b0;
    end else if (expire) begin
      timer_int_q <= 1'b1;
    end
  end

  assign tcfg_o      = {initval_q, tcfg_periodic_q, tcfg_en_q};
  assign tval_o      = tval_q;
  assign timer_int_o = timer_int_q;

endmodule

// File: csr_top.sv
`timescale 1ns/1ps

module csr_top import csr_pkg::*; #(
  parameter csr_data_t CORE_ID = 32'h0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_i,
  input  logic       commit_i,
  input  logic       stall_i,
  input  csr_addr_t  r_addr_i,
  input  rdcnt_t     rdcnt_i,
  input  logic       we_i,
  input  csr_addr_t  w_addr_i,
  input  csr_data_t  w_mask_i,
  input  csr_data_t  w_data_i,
  input  logic       excp_i,
  input  ecode_t     ecode_i,
  input  esubcode_t  esubcode_i,
  input  csr_data_t  pc_i,
  input  logic       ertn_i,
  input  hw_int_t    hw_int_i,
  output csr_data_t  csr_r_data_o,
  output csr_data_t  era_o,
  output csr_data_t  eentry_o,
  output logic [1:0] crmd_plv_o,
  output logic       crmd_ie_o,
  output logic       timer_int_o
);

  logic      wr;
  logic      excp;
  logic      ertn;
  csr_sel_t  wr_sel;
  csr_sel_t  lookup_sel;
  csr_data_t wr_data;
  csr_data_t old_data;
  csr_data_t crmd;
  csr_data_t prmd;
  csr_data_t estat;
  csr_data_t tid;
  csr_data_t tcfg;
  csr_data_t tval;
  csr_data_t count_lo;
  csr_data_t count_hi;

  assign crmd_plv_o = crmd[CRMD_PLV_LSB +: CRMD_PLV_W];
  assign crmd_ie_o  = crmd[CRMD_IE];

  csr_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .commit_i     (commit_i),
    .stall_i      (stall_i),
    .we_i         (we_i),
    .excp_i       (excp_i),
    .ertn_i       (ertn_i),
    .w_addr_i     (w_addr_i),
    .w_mask_i     (w_mask_i),
    .w_data_i     (w_data_i),
    .old_data_i   (old_data),
    .wr_o         (wr),
    .excp_o       (excp),
    .ertn_o       (ertn),
    .wr_sel_o     (wr_sel),
    .wr_data_o    (wr_data),
    .lookup_sel_o (lookup_sel)
  );

  csr_excp_regs u_excp (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .excp_i      (excp),
    .ertn_i      (ertn),
    .wr_sel_i    (wr_sel),
    .wr_data_i   (wr_data),
    .ecode_i     (ecode_i),
    .esubcode_i  (esubcode_i),
    .pc_i        (pc_i),
    .hw_int_i    (hw_int_i),
    .timer_int_i (timer_int_o),
    .crmd_o      (crmd),
    .prmd_o      (prmd),
    .estat_o     (estat),
    .era_o       (era_o),
    .eentry_o    (eentry_o)
  );

  csr_timer u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .wr_sel_i    (wr_sel),
    .wr_data_i   (wr_data),
    .tcfg_o      (tcfg),
    .tval_o      (tval),
    .timer_int_o (timer_int_o)
  );

  csr_counter #(
    .CORE_ID (CORE_ID)
  ) u_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_i       (wr),
    .wr_sel_i   (wr_sel),
    .wr_data_i  (wr_data),
    .tid_o      (tid),
    .count_lo_o (count_lo),
    .count_hi_o (count_hi)
  );

  csr_read_mux u_rd (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .r_addr_i     (r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .lookup_sel_i (lookup_sel),
    .crmd_i       (crmd),
    .prmd_i       (prmd),
    .estat_i      (estat),
    .era_i        (era_o),
    .eentry_i     (eentry_o),
    .tid_i        (tid),
    .tcfg_i       (tcfg),
    .tval_i       (tval),
    .count_lo_i   (count_lo),
    .count_hi_i   (count_hi),
    .r_data_o     (csr_r_data_o),
    .old_data_o   (old_data)
  );

endmodule

// File: files.f
csr_pkg.sv
csr_ctrl.sv
csr_excp_regs.sv
csr_timer.sv
csr_counter.sv
csr_read_mux.sv
csr_top.sv
csr_asserts.sv
tb_csr.sv

// File: tb_csr.sv
`timescale 1ns/1ps

module tb_csr import csr_pkg::*; ();

  localparam int MAX_ENTRIES = 64;
  localparam int TMR_INIT    = 4;

  // check kinds
  localparam int CHK_NONE = 0;
  localparam int CHK_EQ   = 1;
  localparam int CHK_SAME = 2;
  localparam int CHK_MORE = 3;
  localparam int CHK_POLL = 4;

  logic      clk;
  logic      rst_n;
  logic      valid_i;
  logic      commit_i;
  logic      stall_i;
  csr_addr_t r_addr_i;
  rdcnt_t    rdcnt_i;
  logic      we_i;
  csr_addr_t w_addr_i;
  csr_data_t w_mask_i;
  csr_data_t w_data_i;
  logic      excp_i;
  ecode_t    ecode_i;
  esubcode_t esubcode_i;
  csr_data_t pc_i;
  logic      ertn_i;
  hw_int_t   hw_int_i;
  csr_data_t csr_r_data_o;
  csr_data_t era_o;
  csr_data_t eentry_o;
  logic [1:0] crmd_plv_o;
  logic      crmd_ie_o;
  logic      timer_int_o;

  // stimulus table with one entry per cycle
  string     t_name  [MAX_ENTRIES];
  int        t_kind  [MAX_ENTRIES];
  csr_addr_t t_raddr [MAX_ENTRIES];
  rdcnt_t    t_rdcnt [MAX_ENTRIES];
  csr_data_t t_exp   [MAX_ENTRIES];
  logic      t_stall [MAX_ENTRIES];
  logic      t_we    [MAX_ENTRIES];
  csr_addr_t t_waddr [MAX_ENTRIES];
  csr_data_t t_mask  [MAX_ENTRIES];
  csr_data_t t_data  [MAX_ENTRIES];
  logic      t_excp  [MAX_ENTRIES];
  ecode_t    t_ecode [MAX_ENTRIES];
  esubcode_t t_esub  [MAX_ENTRIES];
  csr_data_t t_pc    [MAX_ENTRIES];
  logic      t_ertn  [MAX_ENTRIES];

  int        n_entries;
  int        n_checks;
  int        n_errors;
  int        n_cycles;
  int        cycle_limit;
  integer    seed;
  csr_data_t last_rd;
  csr_data_t rnd_mask;
  csr_data_t rnd_data;

  csr_top #(
    .CORE_ID (32'h5)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .commit_i     (commit_i),
    .stall_i      (stall_i),
    .r_addr_i     (r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .we_i         (we_i),
    .w_addr_i     (w_addr_i),
    .w_mask_i     (w_mask_i),
    .w_data_i     (w_data_i),
    .excp_i       (excp_i),
    .ecode_i      (ecode_i),
    .esubcode_i   (esubcode_i),
    .pc_i         (pc_i),
    .ertn_i       (ertn_i),
    .hw_int_i     (hw_int_i),
    .csr_r_data_o (csr_r_data_o),
    .era_o        (era_o),
    .eentry_o     (eentry_o),
    .crmd_plv_o   (crmd_plv_o),
    .crmd_ie_o    (crmd_ie_o),
    .timer_int_o  (timer_int_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    n_cycles++;
    if (n_cycles > cycle_limit) begin
      $display("timeout at cycle %0d, checks %0d, errors %0d", n_cycles, n_checks, n_errors);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic csr_data_t estat_val(ecode_t code, esubcode_t sub, logic ti);
    return (csr_data_t'(sub) << 22) | (csr_data_t'(code) << 16) | (csr_data_t'(ti) << 11);
  endfunction

  task automatic add_read(input string name, input int kind, input csr_addr_t raddr,
                          input rdcnt_t rdcnt, input csr_data_t exp);
    t_name[n_entries]  = name;
    t_kind[n_entries]  = kind;
    t_raddr[n_entries] = raddr;
    t_rdcnt[n_entries] = rdcnt;
    t_exp[n_entries]   = exp;
    t_stall[n_entries] = 1'b0;
    t_we[n_entries]    = 1'b0;
    t_waddr[n_entries] = '0;
    t_mask[n_entries]  = '0;
    t_data[n_entries]  = '0;
    t_excp[n_entries]  = 1'b0;
    t_ecode[n_entries] = '0;
    t_esub[n_entries]  = '0;
    t_pc[n_entries]    = '0;
    t_ertn[n_entries]  = 1'b0;
    n_entries++;
  endtask

  task automatic with_write(input csr_addr_t waddr, input csr_data_t mask,
                            input csr_data_t data);
    t_we[n_entries-1]    = 1'b1;
    t_waddr[n_entries-1] = waddr;
    t_mask[n_entries-1]  = mask;
    t_data[n_entries-1]  = data;
  endtask

  task automatic with_excp(input ecode_t code, input esubcode_t sub, input csr_data_t pc);
    t_excp[n_entries-1]  = 1'b1;
    t_ecode[n_entries-1] = code;
    t_esub[n_entries-1]  = sub;
    t_pc[n_entries-1]    = pc;
  endtask

  task automatic build_table();
    seed = 32'h646;
    rnd_mask = $random(seed);
    rnd_data = $random(seed);
    // reset values
    add_read("rst_crmd", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h8);
    add_read("rst_tid", CHK_EQ, CSR_CRMD, RDCNT_ID, 32'h5);
    add_read("rst_prmd", CHK_EQ, CSR_PRMD, RDCNT_NONE, 32'h0);
    add_read("rst_estat", CHK_EQ, CSR_ESTAT, RDCNT_NONE, 32'h0);
    add_read("rst_era", CHK_EQ, CSR_ERA, RDCNT_NONE, 32'h0);
    add_read("rst_eentry", CHK_EQ, CSR_EENTRY, RDCNT_NONE, 32'h0);
    add_read("rst_tcfg", CHK_EQ, CSR_TCFG, RDCNT_NONE, 32'h0);
    add_read("rst_tval", CHK_EQ, CSR_TVAL, RDCNT_NONE, 32'h0);
    add_read("rst_ticlr", CHK_EQ, CSR_TICLR, RDCNT_NONE, 32'h0);
    // stable counter
    add_read("cnt_lo_a", CHK_NONE, CSR_CRMD, RDCNT_VLOW, 32'h0);
    add_read("cnt_lo_b", CHK_MORE, CSR_CRMD, RDCNT_VLOW, 32'h0);
    add_read("cnt_hi", CHK_EQ, CSR_CRMD, RDCNT_VHIGH, 32'h0);
    // same-cycle reads of a masked write see the old value
    add_read("era_base", CHK_EQ, CSR_ERA, RDCNT_NONE, 32'h0);
    with_write(CSR_ERA, 32'hffff_ffff, 32'h1234_5678);
    add_read("era_mask", CHK_EQ, CSR_ERA, RDCNT_NONE, 32'h1234_5678);
    with_write(CSR_ERA, rnd_mask, rnd_data);
    add_read("era_rdbk", CHK_EQ, CSR_ERA, RDCNT_NONE,
             (32'h1234_5678 & ~rnd_mask) | (rnd_data & rnd_mask));
    add_read("crmd_wr", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h8);
    with_write(CSR_CRMD, 32'hffff_ffff, 32'hffff_ffff);
    add_read("crmd_rdbk", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h1ff);
    add_read("eentry_wr", CHK_EQ, CSR_EENTRY, RDCNT_NONE, 32'h0);
    with_write(CSR_EENTRY, 32'hffff_ffff, 32'hffff_ffff);
    add_read("eentry_rdbk", CHK_EQ, CSR_EENTRY, RDCNT_NONE, 32'hffff_ffc0);
    // exception entry and return from plv 3 with ie 1
    add_read("crmd_set", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h1ff);
    with_write(CSR_CRMD, 32'hffff_ffff, 32'hf);
    add_read("crmd_chk", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'hf);
    add_read("excp", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'hf);
    with_excp(6'h0b, 9'h1, 32'h1c00_0100);
    add_read("excp_crmd", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h8);
    add_read("excp_prmd", CHK_EQ, CSR_PRMD, RDCNT_NONE, 32'h7);
    add_read("excp_estat", CHK_EQ, CSR_ESTAT, RDCNT_NONE, estat_val(6'h0b, 9'h1, 1'b0));
    add_read("excp_era", CHK_EQ, CSR_ERA, RDCNT_NONE, 32'h1c00_0100);
    add_read("ertn", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h8);
    t_ertn[n_entries-1] = 1'b1;
    add_read("ertn_crmd", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'hf);
    // exception must win when both are set
    add_read("excp_ertn", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'hf);
    with_excp(6'h0c, 9'h0, 32'h1c00_0200);
    t_ertn[n_entries-1] = 1'b1;
    add_read("prio_crmd", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h8);
    add_read("prio_era", CHK_EQ, CSR_ERA, RDCNT_NONE, 32'h1c00_0200);
    // stall blocks commits and holds the read port
    add_read("stall_wr", CHK_SAME, CSR_CRMD, RDCNT_NONE, 32'h0);
    with_write(CSR_ERA, 32'hffff_ffff, 32'hdead_beef);
    t_stall[n_entries-1] = 1'b1;
    add_read("stall_excp", CHK_SAME, CSR_ESTAT, RDCNT_NONE, 32'h0);
    with_excp(6'h01, 9'h0, 32'h1c00_0300);
    t_stall[n_entries-1] = 1'b1;
    add_read("stall_ertn", CHK_SAME, CSR_PRMD, RDCNT_NONE, 32'h0);
    t_ertn[n_entries-1]  = 1'b1;
    t_stall[n_entries-1] = 1'b1;
    add_read("stall_era", CHK_EQ, CSR_ERA, RDCNT_NONE, 32'h1c00_0200);
    add_read("stall_crmd", CHK_EQ, CSR_CRMD, RDCNT_NONE, 32'h8);
    // one-shot timer
    add_read("tcfg_wr", CHK_EQ, CSR_TCFG, RDCNT_NONE, 32'h0);
    with_write(CSR_TCFG, 32'hffff_ffff, (TMR_INIT << 2) | 32'h1);
    add_read("tcfg_rdbk", CHK_EQ, CSR_TCFG, RDCNT_NONE, (TMR_INIT << 2) | 32'h1);
    add_read("timer_poll", CHK_POLL, CSR_ESTAT, RDCNT_NONE, TMR_INIT * 4 + 10);
    add_read("ticlr_wr", CHK_EQ, CSR_ESTAT, RDCNT_NONE, estat_val(6'h0c, 9'h0, 1'b1));
    with_write(CSR_TICLR, 32'h1, 32'h1);
    add_read("ticlr_estat", CHK_EQ, CSR_ESTAT, RDCNT_NONE, estat_val(6'h0c, 9'h0, 1'b0));
    add_read("tval_done", CHK_EQ, CSR_TVAL, RDCNT_NONE, 32'hffff_ffff);
  endtask

  task automatic drive_entry(input int i);
    stall_i    = t_stall[i];
    valid_i    = t_we[i] || t_excp[i] || t_ertn[i];
    commit_i   = t_we[i] || t_excp[i] || t_ertn[i];
    r_addr_i   = t_raddr[i];
    rdcnt_i    = t_rdcnt[i];
    we_i       = t_we[i];
    w_addr_i   = t_waddr[i];
    w_mask_i   = t_mask[i];
    w_data_i   = t_data[i];
    excp_i     = t_excp[i];
    ecode_i    = t_ecode[i];
    esubcode_i = t_esub[i];
    pc_i       = t_pc[i];
    ertn_i     = t_ertn[i];
  endtask

  task automatic check_entry(input int i);
    csr_data_t want;
    want = (t_kind[i] == CHK_SAME) ? last_rd : t_exp[i];
    if (t_kind[i] == CHK_MORE) begin
      n_checks++;
      assert (csr_r_data_o > last_rd) else begin
        n_errors++;
        $display("error %s: expected above %h actual %h", t_name[i], last_rd, csr_r_data_o);
      end
    end else if (t_kind[i] != CHK_NONE) begin
      n_checks++;
      assert (csr_r_data_o == want) else begin
        n_errors++;
        $display("error %s: expected %h actual %h", t_name[i], want, csr_r_data_o);
      end
    end
    last_rd = csr_r_data_o;
  endtask

  // without a commit in the entry the register outputs equal the read value
  task automatic check_outputs(input int i);
    logic quiet;
    quiet = (t_kind[i] == CHK_EQ) && (t_rdcnt[i] == RDCNT_NONE) && !t_stall[i] &&
            !t_we[i] && !t_excp[i] && !t_ertn[i];
    if (quiet && t_raddr[i] == CSR_CRMD) begin
      n_checks++;
      assert (crmd_plv_o == t_exp[i][1:0] && crmd_ie_o == t_exp[i][2]) else begin
        n_errors++;
        $display("error %s: expected plv %h ie %b actual plv %h ie %b", t_name[i],
                 t_exp[i][1:0], t_exp[i][2], crmd_plv_o, crmd_ie_o);
      end
    end
    if (quiet && t_raddr[i] == CSR_ERA) begin
      n_checks++;
      assert (era_o == t_exp[i]) else begin
        n_errors++;
        $display("error %s: expected era_o %h actual %h", t_name[i], t_exp[i], era_o);
      end
    end
    if (quiet && t_raddr[i] == CSR_EENTRY) begin
      n_checks++;
      assert (eentry_o == t_exp[i]) else begin
        n_errors++;
        $display("error %s: expected eentry_o %h actual %h", t_name[i], t_exp[i],
                 eentry_o);
      end
    end
    if (quiet && t_raddr[i] == CSR_ESTAT) begin
      n_checks++;
      assert (timer_int_o == t_exp[i][ESTAT_TI]) else begin
        n_errors++;
        $display("error %s: expected timer_int_o %b actual %b", t_name[i],
                 t_exp[i][ESTAT_TI], timer_int_o);
      end
    end
  endtask

  // t_exp holds the poll limit in cycles
  task automatic wait_timer_int(input int i);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < t_exp[i]) begin
      @(posedge clk);
      @(negedge clk);
      waited++;
      seen = csr_r_data_o[ESTAT_TI];
    end
    n_checks++;
    assert (seen) else begin
      n_errors++;
      $display("error %s: timer interrupt not seen within %0d cycles", t_name[i], t_exp[i]);
    end
    if (seen) begin
      n_checks++;
      assert (timer_int_o) else begin
        n_errors++;
        $display("error %s: expected timer_int_o 1 actual %b", t_name[i], timer_int_o);
      end
    end
    last_rd = csr_r_data_o;
  endtask

  initial begin
    rst_n       = 1'b0;
    hw_int_i    = '0;
    n_entries   = 0;
    n_checks    = 0;
    n_errors    = 0;
    n_cycles    = 0;
    last_rd     = '0;
    add_read("idle", CHK_NONE, CSR_CRMD, RDCNT_NONE, 32'h0);
    drive_entry(0);
    n_entries   = 0;
    build_table();
    cycle_limit = n_entries * 4 + 200;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    n_checks++;
    assert (csr_r_data_o == '0) else begin
      n_errors++;
      $display("error rst_rdata: expected %h actual %h", 32'h0, csr_r_data_o);
    end
    // commits open one cycle after release
    @(negedge clk);
    for (int i = 0; i < n_entries; i++) begin
      drive_entry(i);
      @(posedge clk);
      @(negedge clk);
      if (t_kind[i] == CHK_POLL) begin
        wait_timer_int(i);
      end else begin
        check_entry(i);
        check_outputs(i);
      end
    end
    $display("checks %0d, value errors %0d, assertion failures %0d",
             n_checks, n_errors, u_dut.u_asserts.fail_cnt);
    if (n_errors == 0 && u_dut.u_asserts.fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
